//--- flist.f
pkt_pkg.sv
frame_len_guard.sv
frame_fifo.sv
frame_egress_count.sv
frame_buffer_top.sv
frame_fifo_chk.sv
tb_scoreboard.sv
tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f -o sim_tb
out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"
if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1

//--- tb_top.sv
module tb_top;

  import pkt_pkg::*;

  localparam int TIMEOUT = 2000; // Cycles per wait loop.

  logic             clk;
  logic             rst;
  beat_t            in_beat;
  logic             in_valid;
  logic             in_ready;
  beat_t            out_beat;
  logic             out_valid;
  logic             out_ready;
  logic             status_truncated;
  logic             status_overflow;
  logic             status_bad_frame;
  logic             status_good_frame;
  logic [CNT_W-1:0] frame_count;
  logic [CNT_W-1:0] byte_count;

  logic        ovf_mode;
  logic        test_end;
  int          test_num;
  logic        bp_mode;   // Random out_ready gaps.
  logic [31:0] lfsr;
  int          timeouts;
  int          err_count;
  int          pending;
  int          checks_done;
  int          tests_failed;

  frame_buffer_top DUT (.*);

  tb_scoreboard sb (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken.
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  always @(posedge clk) begin
    logic [31:0] v;
    #1;
    if (bp_mode) begin
      rand_bits(2, v);
      out_ready = (v[1:0] != 2'b00);
    end
  end

  task automatic send_frame(input int len, input logic bad_flag);
    logic [31:0] v;
    int          n;
    logic        done;
    for (int i = 0; i < len; i++) begin
      rand_bits(DATA_W, v);
      in_beat.data = v[DATA_W-1:0];
      in_beat.last = (i == len - 1);
      in_beat.bad  = (i == len - 1) && bad_flag;
      in_valid     = 1'b1;
      n    = 0;
      done = 1'b0;
      while (!done && n < TIMEOUT) begin
        @(negedge clk);
        done = in_ready;
        @(posedge clk);
        #2;
        n++;
      end
      if (!done) begin
        $display("timeout: input beat was never accepted");
        timeouts++;
      end
    end
    in_valid = 1'b0;
    in_beat  = '0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic wait_room(input int limit);
    int n;
    n = 0;
    while (pending > limit && n < TIMEOUT) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (pending > limit) begin
      $display("timeout: buffered frames did not drain");
      timeouts++;
    end
  endtask

  task automatic wait_drain();
    wait_room(0);
    idle(4); // Last status pulses land one cycle after the input.
  endtask

  task automatic finish_test(input int num);
    int n;
    test_num = num;
    test_end = 1'b1;
    idle(1);
    test_end = 1'b0;
    n = 0;
    while (checks_done < num && n < TIMEOUT) begin
      idle(1);
      n++;
    end
    if (checks_done < num) begin
      $display("timeout: scoreboard never finished test %0d", num);
      timeouts++;
    end
  endtask

  initial begin
    logic [31:0] v;
    int          total;
    int          len;
    clk       = 1'b0;
    rst       = 1'b1;
    in_beat   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    ovf_mode  = 1'b0;
    test_end  = 1'b0;
    test_num  = 0;
    bp_mode   = 1'b0;
    lfsr      = 32'hcd19;
    timeouts  = 0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    idle(2);

    for (int i = 1; i <= MAX_FRAME_LEN; i++) begin
      send_frame(i, 1'b0);
    end
    wait_drain();
    finish_test(1);

    for (int i = 0; i < 4; i++) begin
      rand_bits(4, v);
      send_frame(int'(v[3:0]) + 1, 1'b1);
    end
    wait_drain();
    finish_test(2);

    send_frame(20, 1'b0);
    send_frame(8, 1'b0);
    send_frame(30, 1'b0);
    send_frame(5, 1'b0);
    wait_drain();
    finish_test(3);

    out_ready = 1'b0;
    ovf_mode  = 1'b1;
    total     = 0;
    while (total <= 34) begin
      rand_bits(4, v);
      len = 4 + int'(v[3:0]) % 13;
      send_frame(len, 1'b0);
      total += len;
    end
    idle(2);
    out_ready = 1'b1;
    wait_drain();
    ovf_mode = 1'b0;
    finish_test(4);

    bp_mode = 1'b1;
    for (int i = 0; i < 40; i++) begin
      wait_room(MAX_FRAME_LEN); // Keeps the FIFO from overflowing.
      rand_bits(3, v);
      if (v[2:0] == 3'd0) begin
        rand_bits(4, v);
        send_frame(int'(v[3:0]) + 1, 1'b1);
      end else if (v[2:0] == 3'd1) begin
        rand_bits(3, v);
        send_frame(MAX_FRAME_LEN + 1 + int'(v[2:0]), 1'b0);
      end else begin
        rand_bits(4, v);
        send_frame(int'(v[3:0]) + 1, 1'b0);
      end
    end
    wait_drain();
    bp_mode = 1'b0;
    idle(1);
    out_ready = 1'b1;
    finish_test(5);

    $display("summary: 5 tests, %0d failed, %0d errors, %0d timeouts",
             tests_failed, err_count, timeouts);
    if (tests_failed == 0 && err_count == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- tb_scoreboard.sv
module tb_scoreboard (
  input  logic                      clk,
  input  logic                      rst,
  input  pkt_pkg::beat_t            in_beat,
  input  logic                      in_valid,
  input  logic                      in_ready,
  input  pkt_pkg::beat_t            out_beat,
  input  logic                      out_valid,
  input  logic                      out_ready,
  input  logic                      status_truncated,
  input  logic                      status_overflow,
  input  logic                      status_bad_frame,
  input  logic                      status_good_frame,
  input  logic [pkt_pkg::CNT_W-1:0] frame_count,
  input  logic [pkt_pkg::CNT_W-1:0] byte_count,
  input  logic                      ovf_mode,
  input  logic                      test_end,
  input  int                        test_num,
  output int                        err_count,
  output int                        pending,
  output int                        checks_done,
  output int                        tests_failed
);

  import pkt_pkg::*;

  typedef enum int {FATE_GOOD, FATE_BAD, FATE_TRUNC, FATE_OVF} fate_e;

  beat_t cur_q[$];      // Input frame being collected.
  beat_t exp_q[$];      // Beats expected at the output.

  int exp_good, exp_bad, exp_trunc, exp_ovf;
  int obs_good, obs_bad, obs_trunc, obs_ovf;
  int stalled_beats;    // Beats held while out_ready is low.
  int model_frames, model_beats;
  int errs_at_start;

  // Expected fate of a frame as it enters the guard.
  function automatic fate_e predict_fate(input int len, input logic bad_flag,
                                         input logic stalled, input int stored);
    if (len > MAX_FRAME_LEN) begin
      return FATE_TRUNC;
    end
    if (bad_flag) begin
      return FATE_BAD;
    end
    // Stalled buffer holds DEPTH beats plus two in the read pipeline.
    if (stalled && stored + len > DEPTH + 2) begin
      return FATE_OVF;
    end
    return FATE_GOOD;
  endfunction

  task automatic value_error(input string msg);
    $display("error at time %0t: %s", $time, msg);
    err_count++;
  endtask

  task automatic plain_failure(input string msg);
    $display("%s", msg);
    err_count++;
  endtask

  task automatic compare_tallies();
    if (obs_good != exp_good) begin
      value_error($sformatf("good pulses %0d, expected %0d", obs_good, exp_good));
    end
    if (obs_bad != exp_bad) begin
      value_error($sformatf("bad pulses %0d, expected %0d", obs_bad, exp_bad));
    end
    if (obs_trunc != exp_trunc) begin
      value_error($sformatf("truncated pulses %0d, expected %0d", obs_trunc, exp_trunc));
    end
    if (obs_ovf != exp_ovf) begin
      value_error($sformatf("overflow pulses %0d, expected %0d", obs_ovf, exp_ovf));
    end
    if (exp_q.size() != 0) begin
      plain_failure($sformatf("%0d expected beats never came out", exp_q.size()));
    end
    if (frame_count != CNT_W'(model_frames)) begin
      value_error($sformatf("frame_count %0d, expected %0d", frame_count, model_frames));
    end
    if (byte_count != CNT_W'(model_beats)) begin
      value_error($sformatf("byte_count %0d, expected %0d", byte_count, model_beats));
    end
  endtask

  // Sampled on the falling edge, where every signal is settled.
  always @(negedge clk) begin
    beat_t exp;
    fate_e fate;
    int    len;
    if (rst) begin
      cur_q.delete();
      exp_q.delete();
      {exp_good, exp_bad, exp_trunc, exp_ovf} = '0;
      {obs_good, obs_bad, obs_trunc, obs_ovf} = '0;
      stalled_beats = 0;
      model_frames  = 0;
      model_beats   = 0;
      err_count     = 0;
      checks_done   = 0;
      tests_failed  = 0;
      errs_at_start = 0;
    end else begin
      if (status_truncated) obs_trunc++;
      if (status_bad_frame) obs_bad++;
      if (status_good_frame) obs_good++;
      if (status_overflow) obs_ovf++;

      if (!ovf_mode) begin
        stalled_beats = 0;
      end

      if (!in_ready) begin
        value_error("in_ready low, expected high");
      end

      if (in_valid && in_ready) begin
        cur_q.push_back(in_beat);
        if (in_beat.last) begin
          len  = cur_q.size();
          fate = predict_fate(len, in_beat.bad, ovf_mode, stalled_beats);
          case (fate)
            FATE_TRUNC: begin
              exp_trunc++;
              exp_bad++; // Guard closes it as a bad frame.
            end
            FATE_BAD: exp_bad++;
            FATE_OVF: exp_ovf++;
            default: begin
              foreach (cur_q[i]) exp_q.push_back(cur_q[i]);
              exp_good++;
              model_frames++;
              model_beats   += len;
              stalled_beats += len;
            end
          endcase
          cur_q.delete();
        end
      end

      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          value_error($sformatf("unexpected output beat data %02h", out_beat.data));
        end else begin
          exp = exp_q.pop_front();
          if (out_beat !== exp) begin
            value_error($sformatf("got data %02h last %b bad %b, expected %02h %b %b",
                                  out_beat.data, out_beat.last, out_beat.bad,
                                  exp.data, exp.last, exp.bad));
          end
        end
      end

      if (test_end) begin
        compare_tallies();
        if (err_count == errs_at_start) begin
          $display("test %0d passed", test_num);
        end else begin
          $display("test %0d failed with %0d errors", test_num, err_count - errs_at_start);
          tests_failed++;
        end
        errs_at_start = err_count;
        checks_done++;
      end
    end
    pending = exp_q.size();
  end

endmodule

//--- frame_fifo_chk.sv
module frame_fifo_chk (
  input logic           clk,
  input logic           rst,
  input pkt_pkg::beat_t s_beat,
  input logic           s_valid,
  input logic           s_ready,
  input pkt_pkg::beat_t m_beat,
  input logic           m_valid,
  input logic           m_ready,
  input logic           status_overflow,
  input logic           status_bad_frame,
  input logic           status_good_frame
);

  import pkt_pkg::*;

  logic seen_good; // A frame has been committed since reset.

  always_ff @(posedge clk) begin
    if (rst) begin
      seen_good <= 1'b0;
    end else if (status_good_frame) begin
      seen_good <= 1'b1;
    end
  end

  // Every accepted last beat settles its frame with exactly one pulse.
  assert property (@(posedge clk) disable iff (rst)
    s_valid && s_ready && s_beat.last |=>
      $onehot({status_overflow, status_bad_frame, status_good_frame}))
    else $error("last beat did not give exactly one status pulse");

  assert property (@(posedge clk) disable iff (rst)
    !(s_valid && s_ready && s_beat.last) |=>
      !(status_overflow || status_bad_frame || status_good_frame))
    else $error("status pulse without an accepted last beat");

  assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_beat))
    else $error("output beat changed while stalled");

  assert property (@(posedge clk) disable iff (rst)
    !seen_good |-> !m_valid)
    else $error("output valid before any committed frame");

endmodule

bind frame_fifo frame_fifo_chk u_fifo_chk (
  .clk               (clk),
  .rst               (rst),
  .s_beat            (s_beat),
  .s_valid           (s_valid),
  .s_ready           (s_ready),
  .m_beat            (m_beat),
  .m_valid           (m_valid),
  .m_ready           (m_ready),
  .status_overflow   (status_overflow),
  .status_bad_frame  (status_bad_frame),
  .status_good_frame (status_good_frame)
);

//--- frame_buffer_top.sv
module frame_buffer_top (
  input  logic                      clk,
  input  logic                      rst,
  input  pkt_pkg::beat_t            in_beat,
  input  logic                      in_valid,
  output logic                      in_ready,
  output pkt_pkg::beat_t            out_beat,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic                      status_truncated,
  output logic                      status_overflow,
  output logic                      status_bad_frame,
  output logic                      status_good_frame,
  output logic [pkt_pkg::CNT_W-1:0] frame_count,
  output logic [pkt_pkg::CNT_W-1:0] byte_count
);

  import pkt_pkg::*;

  beat_t guard_beat;   // Guard to FIFO.
  logic  guard_valid;
  logic  guard_ready;

  beat_t fifo_beat;    // FIFO to egress.
  logic  fifo_valid;
  logic  fifo_ready;

  frame_len_guard u_guard (
    .clk              (clk),
    .rst              (rst),
    .s_beat           (in_beat),
    .s_valid          (in_valid),
    .s_ready          (in_ready),
    .m_beat           (guard_beat),
    .m_valid          (guard_valid),
    .m_ready          (guard_ready),
    .status_truncated (status_truncated)
  );

  frame_fifo u_fifo (
    .clk               (clk),
    .rst               (rst),
    .s_beat            (guard_beat),
    .s_valid           (guard_valid),
    .s_ready           (guard_ready),
    .m_beat            (fifo_beat),
    .m_valid           (fifo_valid),
    .m_ready           (fifo_ready),
    .status_overflow   (status_overflow),
    .status_bad_frame  (status_bad_frame),
    .status_good_frame (status_good_frame)
  );

  frame_egress_count u_egress (
    .clk         (clk),
    .rst         (rst),
    .s_beat      (fifo_beat),
    .s_valid     (fifo_valid),
    .s_ready     (fifo_ready),
    .m_beat      (out_beat),
    .m_valid     (out_valid),
    .m_ready     (out_ready),
    .frame_count (frame_count),
    .byte_count  (byte_count)
  );

endmodule

//--- frame_egress_count.sv
module frame_egress_count (
  input  logic                      clk,
  input  logic                      rst,
  input  pkt_pkg::beat_t            s_beat,
  input  logic                      s_valid,
  output logic                      s_ready,
  output pkt_pkg::beat_t            m_beat,
  output logic                      m_valid,
  input  logic                      m_ready,
  output logic [pkt_pkg::CNT_W-1:0] frame_count,
  output logic [pkt_pkg::CNT_W-1:0] byte_count
);

  import pkt_pkg::*;

  logic m_xfer;

  // Straight pass-through to the port.
  assign m_beat  = s_beat;
  assign m_valid = s_valid;
  assign s_ready = m_ready;

  assign m_xfer  = m_valid && m_ready;

  // Both totals wrap at 2**CNT_W.
  always_ff @(posedge clk) begin
    if (rst) begin
      frame_count <= '0;
      byte_count  <= '0;
    end else if (m_xfer) begin
      byte_count <= byte_count + 1'b1;  // One byte per beat.
      if (m_beat.last) begin
        frame_count <= frame_count + 1'b1;
      end
    end
  end

endmodule

//--- frame_fifo.sv
module frame_fifo (
  input  logic           clk,
  input  logic           rst,
  input  pkt_pkg::beat_t s_beat,
  input  logic           s_valid,
  output logic           s_ready,
  output pkt_pkg::beat_t m_beat,
  output logic           m_valid,
  input  logic           m_ready,
  output logic           status_overflow,
  output logic           status_bad_frame,
  output logic           status_good_frame
);

  import pkt_pkg::*;

  // Pointers carry one extra wrap bit.
  logic [ADDR_W:0] wr_ptr;        // End of the last committed frame.
  logic [ADDR_W:0] wr_ptr_next;
  logic [ADDR_W:0] wr_ptr_cur;    // Write position inside the open frame.
  logic [ADDR_W:0] wr_ptr_cur_next;
  logic [ADDR_W:0] rd_ptr;
  logic [ADDR_W:0] rd_ptr_next;

  beat_t mem [DEPTH];
  beat_t mem_rd_beat;             // Memory output register.
  logic  mem_rd_valid;
  logic  mem_rd_valid_next;

  logic full_cur;
  logic empty;
  logic write;
  logic read;
  logic store_output;

  logic drop_frame;
  logic drop_frame_next;
  logic overflow_next;
  logic bad_frame_next;
  logic good_frame_next;

  // Open frame has caught up with the reader.
  assign full_cur = (wr_ptr_cur[ADDR_W] != rd_ptr[ADDR_W]) &&
                    (wr_ptr_cur[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
  assign empty    = (wr_ptr == rd_ptr); // Nothing committed to read.

  // Frames that do not fit are dropped, so input is never stalled.
  assign s_ready  = 1'b1;

  always_comb begin
    write           = 1'b0;
    drop_frame_next = drop_frame;
    overflow_next   = 1'b0;
    bad_frame_next  = 1'b0;
    good_frame_next = 1'b0;
    wr_ptr_next     = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    if (s_valid && s_ready) begin
      if (full_cur || drop_frame) begin
        drop_frame_next = 1'b1;
        if (s_beat.last) begin
          wr_ptr_cur_next = wr_ptr; // Rewind over the partial frame.
          drop_frame_next = 1'b0;
          overflow_next   = 1'b1;
        end
      end else begin
        write           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (s_beat.last) begin
          if (s_beat.bad) begin
            wr_ptr_cur_next = wr_ptr;
            bad_frame_next  = 1'b1;
          end else begin
            wr_ptr_next     = wr_ptr_cur + 1'b1; // Commit.
            good_frame_next = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr            <= '0;
      wr_ptr_cur        <= '0;
      drop_frame        <= 1'b0;
      status_overflow   <= 1'b0;
      status_bad_frame  <= 1'b0;
      status_good_frame <= 1'b0;
    end else begin
      wr_ptr            <= wr_ptr_next;
      wr_ptr_cur        <= wr_ptr_cur_next;
      drop_frame        <= drop_frame_next;
      status_overflow   <= overflow_next;
      status_bad_frame  <= bad_frame_next;
      status_good_frame <= good_frame_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur[ADDR_W-1:0]] <= s_beat;
    end
  end

  // Output register accepts when empty or being drained.
  assign store_output = m_ready || !m_valid;

  always_comb begin
    read              = 1'b0;
    rd_ptr_next       = rd_ptr;
    mem_rd_valid_next = mem_rd_valid;
    if (store_output || !mem_rd_valid) begin
      if (!empty) begin
        read              = 1'b1;
        mem_rd_valid_next = 1'b1;
        rd_ptr_next       = rd_ptr + 1'b1;
      end else begin
        mem_rd_valid_next = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr       <= '0;
      mem_rd_valid <= 1'b0;
      m_valid      <= 1'b0;
    end else begin
      rd_ptr       <= rd_ptr_next;
      mem_rd_valid <= mem_rd_valid_next;
      if (store_output) begin
        m_valid <= mem_rd_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      mem_rd_beat <= mem[rd_ptr[ADDR_W-1:0]];
    end
    if (store_output) begin
      m_beat <= mem_rd_beat; // Held while stalled.
    end
  end

endmodule

//--- frame_len_guard.sv
module frame_len_guard (
  input  logic           clk,
  input  logic           rst,
  input  pkt_pkg::beat_t s_beat,
  input  logic           s_valid,
  output logic           s_ready,
  output pkt_pkg::beat_t m_beat,
  output logic           m_valid,
  input  logic           m_ready,
  output logic           status_truncated
);

  import pkt_pkg::*;

  logic [LEN_W-1:0] beat_cnt;   // Beats already passed in the current frame.
  logic             discard;    // Dropping the tail of a cut frame.
  logic             at_limit;
  logic             s_xfer;
  logic             cut_now;

  assign at_limit = (beat_cnt == LEN_W'(MAX_FRAME_LEN - 1));
  assign s_xfer   = s_valid && s_ready;

  // Limit reached on a beat that does not end the frame.
  assign cut_now  = !discard && at_limit && !s_beat.last;

  // While discarding, the tail is swallowed and nothing goes downstream.
  assign s_ready  = m_ready || discard;
  assign m_valid  = s_valid && !discard;

  always_comb begin
    m_beat = s_beat;
    if (cut_now) begin
      m_beat.last = 1'b1; // Close the frame here.
      m_beat.bad  = 1'b1; // And mark it for dropping.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt         <= '0;
      discard          <= 1'b0;
      status_truncated <= 1'b0;
    end else begin
      status_truncated <= s_xfer && cut_now;
      if (s_xfer) begin
        if (discard) begin
          // Real end of the oversize frame.
          if (s_beat.last) begin
            discard <= 1'b0;
          end
        end else if (s_beat.last) begin
          beat_cnt <= '0;
        end else if (at_limit) begin
          beat_cnt <= '0;
          discard  <= 1'b1;
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- pkt_pkg.sv
package pkt_pkg;

  // Stream and buffer geometry.
  localparam int DATA_W = 8;          // One byte per beat.
  localparam int ADDR_W = 5;          // FIFO address width.
  localparam int DEPTH = 2 ** ADDR_W; // 32 beats of storage.

  // Frame length limit enforced ahead of the FIFO.
  localparam int MAX_FRAME_LEN = 16;
  localparam int LEN_W = $clog2(MAX_FRAME_LEN); // Counts beats 0 .. MAX_FRAME_LEN-1.

  // Delivered frame and byte totals.
  localparam int CNT_W = 16;

  // One beat of the packet stream, used on every link.
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last; // Final beat of a frame.
    logic              bad;  // Only meaningful when last is set.
  } beat_t;

endpackage
